/* hdl/exec_pkg.sv */
// execute stage package: shared types, operation codes, bus structs and trap numbers
`default_nettype none

package exec_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0]  bit_idx_t;
	typedef logic [1:0]  sub_t;       // access size for memory ops
	typedef logic [3:0]  y1_sel_t;
	typedef logic [1:0]  y2_sel_t;    // 0 none, 1 flag, 2 sp
	typedef logic [7:0]  irq_num_t;

	typedef enum logic [4:0] {
		op_shift = 5'd5,
		op_logic = 5'd6,
		op_mem   = 5'd7,
		op_move  = 5'd9,
		op_sext  = 5'd18,
		op_bitf  = 5'd19,
		op_cmpu  = 5'd20,
		op_cmps  = 5'd21
	} op_t;

	typedef enum logic [1:0] {unit_shl, unit_bfc, unit_mem, unit_none} unit_t;

	typedef enum logic [1:0] {ms_idle, ms_busy, ms_done} mem_state_t;

	typedef struct packed {
		logic     valid;
		op_t      op;
		sub_t     sub;
		logic     dir;      // 1 = write, also compare code msb
		word_t    x1;
		word_t    x2;
		bit_idx_t msb;
		bit_idx_t lsb;
		y1_sel_t  y1_sel;
		y2_sel_t  y2_sel;
		addr_t    pc;
		logic     irq;
		irq_num_t irq_num;
	} exec_req_t;

	typedef struct packed {
		logic     valid;
		y1_sel_t  y1_sel;
		y2_sel_t  y2_sel;
		word_t    y1;
		word_t    y2;
		addr_t    pc;
		logic     irq;
		irq_num_t irq_num;
	} exec_res_t;

	typedef struct packed {
		word_t y1;
		word_t y2;
	} unit_out_t;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		addr_t      adr;
		word_t      dat;
		logic [3:0] sel;
	} wb_m2s_t;

	typedef struct packed {
		word_t dat;
		logic  ack;
	} wb_s2m_t;

	localparam irq_num_t IRQ_SHL_RANGE = 8'd6;
	localparam irq_num_t IRQ_SHR_RANGE = 8'd7;

endpackage

`default_nettype wire

/* hdl/exec_decode.sv */
// execute decode: picks the functional unit, flags shift range traps, gates channel selects
`timescale 1ns/1ps
`default_nettype none

module exec_decode
	import exec_pkg::*;
(
	input  exec_req_t req,
	output unit_t     unit,
	output logic      mem_go,
	output logic      trap,
	output irq_num_t  trap_num,
	output y1_sel_t   y1_sel,
	output y2_sel_t   y2_sel
);

	logic kill;   // no register writeback

	always_comb begin
		case (req.op)
			op_shift, op_logic, op_move, op_sext: unit = unit_shl;
			op_bitf, op_cmpu, op_cmps:            unit = unit_bfc;
			op_mem:                               unit = unit_mem;
			default:                              unit = unit_none;
		endcase
	end

	// size 0 means no bus access at all
	assign mem_go = req.valid && (req.op == op_mem) && (req.sub != 2'd0);

	always_comb begin
		trap     = 1'b0;
		trap_num = '0;
		if (req.valid && (req.op == op_shift) && (req.x2 > 32'd32)) begin
			trap = 1'b1;
			// odd sub codes shift to the right
			trap_num = req.sub[0] ? IRQ_SHR_RANGE : IRQ_SHL_RANGE;
		end
	end

	assign kill = !req.valid || trap || (unit == unit_none);

	always_comb begin
		if (kill) begin
			y1_sel = '0;
			y2_sel = '0;
		end else begin
			y1_sel = req.y1_sel;
			y2_sel = req.y2_sel;
		end
	end

endmodule

`default_nettype wire

/* hdl/shift_logic_unit.sv */
// shift/rotate, bitwise logic, move and sign extension datapath
`timescale 1ns/1ps
`default_nettype none

module shift_logic_unit
	import exec_pkg::*;
(
	input  exec_req_t req,
	output unit_out_t out
);

	logic [63:0] lsh;   // x1 in the low half, moved up
	logic [63:0] rsh;   // x1 in the high half, moved down
	logic        x1_nz;
	logic        x2_nz;

	assign lsh   = {32'd0, req.x1} << req.x2;
	assign rsh   = {req.x1, 32'd0} >> req.x2;
	assign x1_nz = |req.x1;
	assign x2_nz = |req.x2;

	always_comb begin
		out = '0;
		case (req.op)
			op_shift: begin
				case (req.sub)
					2'd0: begin
						out.y1 = lsh[31:0];
						out.y2 = lsh[63:32];
					end
					2'd1: begin
						out.y1 = rsh[63:32];
						out.y2 = rsh[31:0];   // dropped bits, top aligned
					end
					2'd2: begin
						out.y1 = lsh[31:0] | lsh[63:32];
						out.y2 = lsh[63:32];
					end
					default: begin
						out.y1 = rsh[63:32] | rsh[31:0];
						out.y2 = rsh[31:0];
					end
				endcase
			end
			op_logic: begin
				case (req.sub)
					2'd0: begin
						out.y1    = req.x1 & req.x2;
						out.y2[0] = x1_nz && x2_nz;
					end
					2'd1: begin
						out.y1    = req.x1 | req.x2;
						out.y2[0] = x1_nz || x2_nz;
					end
					2'd2: begin
						out.y1    = ~req.x2;
						out.y2[0] = !x2_nz;
					end
					default: begin
						out.y1    = req.x1 ^ req.x2;
						out.y2[0] = x1_nz ^ x2_nz;
					end
				endcase
			end
			op_move: out.y1 = req.x2;
			op_sext: begin
				case (req.sub)
					2'd0:    out.y1 = {{24{req.x2[7]}}, req.x2[7:0]};
					2'd1:    out.y1 = {{16{req.x2[15]}}, req.x2[15:0]};
					default: out.y1 = req.x2;
				endcase
			end
			default: out = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/bitfield_compare_unit.sv */
// bitfield insert/extract and unsigned/signed compare
`timescale 1ns/1ps
`default_nettype none

module bitfield_compare_unit
	import exec_pkg::*;
(
	input  exec_req_t req,
	output unit_out_t out
);

	word_t    mask;
	bit_idx_t top_gap;
	logic     eq;
	logic     gt;
	logic     lt;
	logic     flag;

	// bits msb..lsb, empty when msb < lsb
	assign top_gap = 5'd31 - req.msb;
	assign mask    = ({32{1'b1}} >> top_gap) & ({32{1'b1}} << req.lsb);

	assign eq = (req.x1 == req.x2);

	always_comb begin
		if (req.op == op_cmps) begin
			gt = $signed(req.x1) > $signed(req.x2);
			lt = $signed(req.x1) < $signed(req.x2);
		end else begin
			gt = req.x1 > req.x2;
			lt = req.x1 < req.x2;
		end
	end

	always_comb begin
		case ({req.dir, req.sub})
			3'd0:    flag = eq;
			3'd1:    flag = !eq;
			3'd2:    flag = gt;
			3'd3:    flag = lt;
			3'd4:    flag = !lt;   // ge
			3'd5:    flag = !gt;   // le
			default: flag = 1'b0;
		endcase
	end

	always_comb begin
		out = '0;
		case (req.op)
			op_bitf: begin
				case (req.sub)
					2'd0:    out.y1 = (req.x1 & ~mask) | ((req.x2 << req.lsb) & mask);
					2'd1:    out.y1 = (req.x2 & mask) >> req.lsb;
					default: out.y1 = '0;
				endcase
			end
			op_cmpu, op_cmps: begin
				out.y1 = '0;
				out.y2 = {31'd0, flag};
			end
			default: out = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/mem_access_unit.sv */
// data memory master: one wishbone classic cycle per request, sized lanes and masked reads
`timescale 1ns/1ps
`default_nettype none

module mem_access_unit
	import exec_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  exec_req_t req,
	input  wire logic go,
	input  wire logic hold,
	input  wb_s2m_t   wb_in,
	output wb_m2s_t   wb_out,
	output word_t     rdata,
	output logic      done,
	output logic      busy
);

	mem_state_t state;
	logic       start;
	logic [3:0] sel_d;
	logic [3:0] sel_q;
	addr_t      adr_q;
	word_t      dat_q;
	logic       we_q;
	word_t      lane_mask;

	always_comb begin
		case (req.sub)
			2'd1:    sel_d = 4'b0001;
			2'd2:    sel_d = 4'b0011;
			2'd3:    sel_d = 4'b1111;
			default: sel_d = 4'b0000;
		endcase
	end

	assign start = (state == ms_idle) && go && !hold;
	assign done  = (state == ms_busy) && wb_in.ack;
	assign busy  = go && !done;   // released in the ack cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ms_idle;
		end else begin
			case (state)
				ms_idle: if (start) state <= ms_busy;
				ms_busy: if (wb_in.ack) state <= ms_done;
				default: state <= ms_idle;
			endcase
		end
	end

	// address and data stay put until ack
	always_ff @(posedge clk) begin
		if (start) begin
			adr_q <= req.x2;
			dat_q <= req.x1;
			we_q  <= req.dir;
			sel_q <= sel_d;
		end
	end

	always_comb begin
		wb_out.cyc = (state == ms_busy);
		wb_out.stb = (state == ms_busy);
		wb_out.we  = we_q;
		wb_out.adr = adr_q;
		wb_out.dat = dat_q;
		wb_out.sel = sel_q;
	end

	assign lane_mask = {{8{sel_q[3]}}, {8{sel_q[2]}}, {8{sel_q[1]}}, {8{sel_q[0]}}};
	assign rdata     = done ? (wb_in.dat & lane_mask) : '0;

endmodule

`default_nettype wire

/* hdl/result_reg.sv */
// stage output register: unit result select, trap merge, freeze on hold and stall
`timescale 1ns/1ps
`default_nettype none

module result_reg
	import exec_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  exec_req_t req,
	input  wire logic hold,
	input  wire logic busy,
	input  unit_t     unit,
	input  unit_out_t shl,
	input  unit_out_t bfc,
	input  word_t     rdata,
	input  wire logic trap,
	input  irq_num_t  trap_num,
	input  y1_sel_t   y1_sel,
	input  y2_sel_t   y2_sel,
	output exec_res_t res
);

	unit_out_t sel_out;

	always_comb begin
		case (unit)
			unit_shl: sel_out = shl;
			unit_bfc: sel_out = bfc;
			unit_mem: begin
				sel_out.y1 = req.dir ? '0 : rdata;   // stores return nothing
				sel_out.y2 = '0;
			end
			default:  sel_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res.valid  <= 1'b0;
			res.irq    <= 1'b0;
			res.y1_sel <= '0;
			res.y2_sel <= '0;
		end else if (!hold && !busy) begin
			res.valid   <= req.valid;
			res.y1_sel  <= y1_sel;
			res.y2_sel  <= y2_sel;
			res.y1      <= sel_out.y1;
			res.y2      <= sel_out.y2;
			res.pc      <= req.pc;
			// upstream interrupt wins over a local trap
			res.irq     <= req.irq || trap;
			res.irq_num <= req.irq ? req.irq_num : trap_num;
		end
	end

endmodule

`default_nettype wire

/* hdl/exec_stage.sv */
// execute stage top: decode, datapath units, wishbone master and output register
`timescale 1ns/1ps
`default_nettype none

module exec_stage
	import exec_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  exec_req_t req,
	input  wire logic hold,
	input  wb_s2m_t   wb_in,
	output exec_res_t res,
	output logic      stall,
	output wb_m2s_t   wb_out
);

	unit_t     unit;
	logic      mem_go;
	logic      trap;
	irq_num_t  trap_num;
	y1_sel_t   y1_sel;
	y2_sel_t   y2_sel;
	unit_out_t shl_out;
	unit_out_t bfc_out;
	word_t     rdata;

	exec_decode u_decode (
		.req      (req),
		.unit     (unit),
		.mem_go   (mem_go),
		.trap     (trap),
		.trap_num (trap_num),
		.y1_sel   (y1_sel),
		.y2_sel   (y2_sel)
	);

	shift_logic_unit u_shl (
		.req (req),
		.out (shl_out)
	);

	bitfield_compare_unit u_bfc (
		.req (req),
		.out (bfc_out)
	);

	mem_access_unit u_mem (
		.clk    (clk),
		.rst    (rst),
		.req    (req),
		.go     (mem_go),
		.hold   (hold),
		.wb_in  (wb_in),
		.wb_out (wb_out),
		.rdata  (rdata),
		.done   (),        // completion is already folded into busy
		.busy   (stall)
	);

	result_reg u_res (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.hold     (hold),
		.busy     (stall),
		.unit     (unit),
		.shl      (shl_out),
		.bfc      (bfc_out),
		.rdata    (rdata),
		.trap     (trap),
		.trap_num (trap_num),
		.y1_sel   (y1_sel),
		.y2_sel   (y2_sel),
		.res      (res)
	);

endmodule

`default_nettype wire

/* tests/exec_vectors.svh */
// execute stage test vectors with their expected stage results
// columns are op, sub, dir, x1, x2, msb, lsb, {y1_sel,y2_sel}, irq in, hold cycles,
// then expected y1, expected y2, channels zeroed and irq number (0 for none)
task automatic load_vectors();
	// shifts by 0, 1, 31 and 32, then rotates
	add_row(op_shift, 0, 0, 'h80000001, 0, 0, 0, 'h0d, 0, 0, 'h80000001, 'h00000000, 0, 0);
	add_row(op_shift, 0, 0, 'h80000001, 1, 0, 0, 'h0d, 0, 0, 'h00000002, 'h00000001, 0, 0);
	add_row(op_shift, 0, 0, 'h80000001, 31, 0, 0, 'h16, 0, 0, 'h80000000, 'h40000000, 0, 0);
	add_row(op_shift, 0, 0, 'h80000001, 32, 0, 0, 'h16, 0, 0, 'h00000000, 'h80000001, 0, 0);
	add_row(op_shift, 1, 0, 'h80000001, 0, 0, 0, 'h25, 0, 0, 'h80000001, 'h00000000, 0, 0);
	add_row(op_shift, 1, 0, 'h80000001, 1, 0, 0, 'h25, 0, 0, 'h40000000, 'h80000000, 0, 0);
	add_row(op_shift, 1, 0, 'h80000001, 31, 0, 0, 'h25, 0, 0, 'h00000001, 'h00000002, 0, 0);
	add_row(op_shift, 1, 0, 'h80000001, 32, 0, 0, 'h25, 0, 0, 'h00000000, 'h80000001, 0, 0);
	add_row(op_shift, 2, 0, 'h12345678, 0, 0, 0, 'h3c, 0, 0, 'h12345678, 'h00000000, 0, 0);
	add_row(op_shift, 2, 0, 'h80000001, 1, 0, 0, 'h3c, 0, 0, 'h00000003, 'h00000001, 0, 0);
	add_row(op_shift, 2, 0, 'h80000001, 31, 0, 0, 'h3c, 0, 0, 'hc0000000, 'h40000000, 0, 0);
	add_row(op_shift, 3, 0, 'h12345678, 8, 0, 0, 'h3c, 0, 0, 'h78123456, 'h78000000, 0, 0);
	add_row(op_shift, 3, 0, 'h12345678, 32, 0, 0, 'h3c, 0, 0, 'h12345678, 'h12345678, 0, 0);
	// amounts above 32
	add_row(op_shift, 0, 0, 'h00000000, 33, 0, 0, 'h0d, 0, 0, 'h0, 'h0, 1, 6);
	add_row(op_shift, 1, 0, 'h00000000, 100, 0, 0, 'h0d, 0, 0, 'h0, 'h0, 1, 7);
	add_row(op_shift, 3, 0, 'h00000000, 'hffffffff, 0, 0, 'h16, 0, 0, 'h0, 'h0, 1, 7);
	// logic, move, sign extension, invalid op
	add_row(op_logic, 0, 0, 'hffffffff, 'h0f0f0f0f, 0, 0, 'h0d, 0, 0, 'h0f0f0f0f, 'h1, 0, 0);
	add_row(op_logic, 1, 0, 'h80000000, 'h00000001, 0, 0, 'h0d, 0, 0, 'h80000001, 'h1, 0, 0);
	add_row(op_logic, 2, 0, 'h12345678, 'h00000000, 0, 0, 'h16, 0, 0, 'hffffffff, 'h1, 0, 0);
	add_row(op_logic, 2, 0, 'h00000000, 'hffffffff, 0, 0, 'h16, 0, 0, 'h00000000, 'h0, 0, 0);
	add_row(op_logic, 3, 0, 'hffffffff, 'hffffffff, 0, 0, 'h25, 0, 0, 'h00000000, 'h0, 0, 0);
	add_row(op_logic, 3, 0, 'h00000000, 'h80000000, 0, 0, 'h25, 0, 0, 'h80000000, 'h1, 0, 0);
	add_row(op_move, 0, 0, 'h11111111, 'hdeadbeef, 0, 0, 'h3c, 0, 0, 'hdeadbeef, 'h0, 0, 0);
	add_row(op_sext, 0, 0, 'h00000000, 'h00000080, 0, 0, 'h0d, 0, 0, 'hffffff80, 'h0, 0, 0);
	add_row(op_sext, 1, 0, 'h00000000, 'h00008000, 0, 0, 'h0d, 0, 0, 'hffff8000, 'h0, 0, 0);
	add_row(op_sext, 1, 0, 'h00000000, 'hffff7fff, 0, 0, 'h0d, 0, 0, 'h00007fff, 'h0, 0, 0);
	add_row(1, 0, 0, 'h12345678, 'h12345678, 0, 0, 'h3c, 0, 0, 'h0, 'h0, 1, 0);
	// bitfield set and get
	add_row(op_bitf, 0, 0, 'hffffffff, 'h00000000, 7, 4, 'h0d, 0, 0, 'hffffff0f, 'h0, 0, 0);
	add_row(op_bitf, 0, 0, 'h12345678, 'h000000ab, 15, 8, 'h0d, 0, 0, 'h1234ab78, 'h0, 0, 0);
	add_row(op_bitf, 1, 0, 'h00000000, 'h12345678, 15, 8, 'h16, 0, 0, 'h00000056, 'h0, 0, 0);
	add_row(op_bitf, 1, 0, 'h00000000, 'h80000000, 31, 31, 'h16, 0, 0, 'h00000001, 'h0, 0, 0);
	add_row(op_bitf, 1, 0, 'h00000000, 'hdeadbeef, 11, 4, 'h16, 0, 0, 'h000000ee, 'h0, 0, 0);
	// compares, code {dir,sub} is eq ne gt lt ge le
	add_row(op_cmpu, 0, 0, 'h80000000, 'h80000000, 0, 0, 'h05, 0, 0, 'h0, 'h1, 0, 0);
	add_row(op_cmpu, 1, 0, 'h80000000, 'h00000001, 0, 0, 'h05, 0, 0, 'h0, 'h1, 0, 0);
	add_row(op_cmpu, 2, 0, 'h80000000, 'h00000001, 0, 0, 'h05, 0, 0, 'h0, 'h1, 0, 0);
	add_row(op_cmpu, 3, 0, 'h80000000, 'h00000001, 0, 0, 'h05, 0, 0, 'h0, 'h0, 0, 0);
	add_row(op_cmpu, 0, 1, 'h80000000, 'h00000001, 0, 0, 'h05, 0, 0, 'h0, 'h1, 0, 0);
	add_row(op_cmpu, 1, 1, 'hffffffff, 'hffffffff, 0, 0, 'h05, 0, 0, 'h0, 'h1, 0, 0);
	add_row(op_cmps, 2, 0, 'h80000000, 'h00000001, 0, 0, 'h09, 0, 0, 'h0, 'h0, 0, 0);
	add_row(op_cmps, 3, 0, 'h80000000, 'h00000001, 0, 0, 'h09, 0, 0, 'h0, 'h1, 0, 0);
	add_row(op_cmps, 0, 1, 'hffffffff, 'h00000000, 0, 0, 'h09, 0, 0, 'h0, 'h0, 0, 0);
	add_row(op_cmps, 1, 1, 'h80000000, 'h7fffffff, 0, 0, 'h09, 0, 0, 'h0, 'h1, 0, 0);
	add_row(op_cmps, 0, 0, 'hffffffff, 'hffffffff, 0, 0, 'h09, 0, 0, 'h0, 'h1, 0, 0);
	add_row(op_cmps, 1, 0, 'hffffffff, 'hffffffff, 0, 0, 'h09, 0, 0, 'h0, 'h0, 0, 0);
	// memory, sub is the access size and x2 the byte address
	add_row(op_mem, 3, 1, 'h12345678, 'h10, 0, 0, 'h1c, 0, 0, 'h00000000, 'h0, 0, 0);
	add_row(op_mem, 3, 0, 'h00000000, 'h10, 0, 0, 'h1c, 0, 0, 'h12345678, 'h0, 0, 0);
	add_row(op_mem, 1, 1, 'haabbccdd, 'h14, 0, 0, 'h20, 0, 0, 'h00000000, 'h0, 0, 0);
	add_row(op_mem, 3, 0, 'h00000000, 'h14, 0, 0, 'h20, 0, 0, 'h8ea8f5dd, 'h0, 0, 0);
	add_row(op_mem, 2, 0, 'h00000000, 'h14, 0, 0, 'h20, 0, 0, 'h0000f5dd, 'h0, 0, 0);
	add_row(op_mem, 3, 0, 'h00000000, 'h08, 0, 0, 'h24, 0, 0, 'h89aff20f, 'h0, 0, 0);
	// held rows, then upstream interrupts
	add_row(op_move, 0, 0, 'h00000000, 'h0badcafe, 0, 0, 'h2d, 0, 3, 'h0badcafe, 'h0, 0, 0);
	add_row(op_logic, 3, 0, 'hf0f0f0f0, 'h0ff00ff0, 0, 0, 'h2d, 0, 2, 'hff00ff00, 'h0, 0, 0);
	add_row(op_shift, 0, 0, 'h00000000, 40, 0, 0, 'h0d, 'h21, 0, 'h0, 'h0, 1, 'h21);
	add_row(op_move, 0, 0, 'h00000000, 'h00000005, 0, 0, 'h0d, 'h30, 0, 'h5, 'h0, 0, 'h30);
endtask

/* tests/exec_stage_tb.sv */
// execute stage testbench driving a table of operations against a wishbone memory model
`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb
	import exec_pkg::*;
();

	typedef struct packed {
		logic [4:0] op;
		sub_t       sub;
		logic       dir;
		word_t      x1;
		word_t      x2;
		bit_idx_t   msb;
		bit_idx_t   lsb;
		logic [5:0] sel;      // y1_sel over y2_sel
		irq_num_t   irq_in;   // 0 means no upstream irq
		logic [3:0] hold_n;
		word_t      y1;
		word_t      y2;
		logic       kill;     // both channels expected zero
		irq_num_t   irq;
	} vec_t;

	localparam int CYCLES_PER_ROW = 20;
	localparam int CYCLE_MARGIN   = 40;

	logic      clk;
	logic      rst;
	logic      hold;
	exec_req_t req;
	wb_s2m_t   wb_in;
	exec_res_t res;
	logic      stall;
	wb_m2s_t   wb_out;

	vec_t       vecs[$];
	word_t      mem[16];
	logic [3:0] mem_idx;
	int         lane;
	int         seed;
	int         errors;
	int         cycles;
	int         cycle_limit;
	int         wait_n;
	int         wait_target;

	exec_stage dut_i (
		.clk    (clk),
		.rst    (rst),
		.req    (req),
		.hold   (hold),
		.wb_in  (wb_in),
		.res    (res),
		.stall  (stall),
		.wb_out (wb_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic report_mismatch(input string msg);
		errors++;
		$display("MISMATCH at %0d ns: %s", $time, msg);
	endtask

	task automatic add_row(input logic [4:0] op, input sub_t sub, input logic dir,
			input word_t x1, input word_t x2, input bit_idx_t msb, input bit_idx_t lsb,
			input logic [5:0] sel, input irq_num_t irq_in, input logic [3:0] hold_n,
			input word_t y1, input word_t y2, input logic kill, input irq_num_t irq);
		vecs.push_back({op, sub, dir, x1, x2, msb, lsb, sel, irq_in, hold_n, y1, y2, kill, irq});
	endtask

	`include "exec_vectors.svh"

	// wishbone slave with 0 to 3 wait states before ack
	always begin
		@(posedge clk);
		#1;
		if (rst) begin
			wb_in.ack = 1'b0;
			wait_n    = 0;
		end else if (wb_in.ack) begin
			wb_in.ack   = 1'b0;   // single cycle ack
			wait_n      = 0;
			wait_target = $unsigned($random(seed)) % 4;
		end else if (wb_out.cyc && wb_out.stb) begin
			if (wait_n < wait_target) begin
				wait_n++;
			end else begin
				mem_idx   = wb_out.adr[5:2];
				wb_in.dat = mem[mem_idx];
				for (lane = 0; lane < 4; lane++) begin
					if (wb_out.we && wb_out.sel[lane])
						mem[mem_idx][8*lane +: 8] = wb_out.dat[8*lane +: 8];
				end
				wb_in.ack = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles with %0d errors", cycles, errors);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic run_row(input int n);
		vec_t      v;
		exec_res_t prev;
		y1_sel_t   e_y1_sel;
		y2_sel_t   e_y2_sel;
		v           = vecs[n];
		prev        = res;
		req         = '0;
		req.valid   = 1'b1;
		req.op      = op_t'(v.op);
		req.sub     = v.sub;
		req.dir     = v.dir;
		req.x1      = v.x1;
		req.x2      = v.x2;
		req.msb     = v.msb;
		req.lsb     = v.lsb;
		req.y1_sel  = v.sel[5:2];
		req.y2_sel  = v.sel[1:0];
		req.pc      = 32'h100 + 4 * n;
		req.irq     = (v.irq_in != 0);
		req.irq_num = v.irq_in;
		hold        = (v.hold_n != 0);
		repeat (v.hold_n) begin
			@(posedge clk);
			#1;
			if (res !== prev)
				report_mismatch($sformatf("row %0d res changed while held", n));
		end
		hold = 1'b0;
		@(negedge clk);
		if (v.op == op_mem && v.sub != 0 && stall !== 1'b1)
			report_mismatch($sformatf("row %0d stall low before ack", n));
		while (stall) begin
			if (res !== prev)
				report_mismatch($sformatf("row %0d res changed during stall", n));
			@(negedge clk);
		end
		if (v.op == op_mem && v.sub != 0 && wb_in.ack !== 1'b1)
			report_mismatch($sformatf("row %0d stall released without ack", n));
		@(posedge clk);
		#1;
		e_y1_sel = v.kill ? 4'd0 : v.sel[5:2];
		e_y2_sel = v.kill ? 2'd0 : v.sel[1:0];
		if (res.valid !== 1'b1 || res.pc !== 32'h100 + 4 * n)
			report_mismatch($sformatf("row %0d valid %b pc %h", n, res.valid, res.pc));
		if (res.y1 !== v.y1 || res.y2 !== v.y2)
			report_mismatch($sformatf("row %0d y1 %h y2 %h, expected %h %h",
				n, res.y1, res.y2, v.y1, v.y2));
		if (res.y1_sel !== e_y1_sel || res.y2_sel !== e_y2_sel)
			report_mismatch($sformatf("row %0d channels %h %h, expected %h %h",
				n, res.y1_sel, res.y2_sel, e_y1_sel, e_y2_sel));
		if (res.irq !== (v.irq != 0) || res.irq_num !== v.irq)
			report_mismatch($sformatf("row %0d irq %b num %h, expected num %h",
				n, res.irq, res.irq_num, v.irq));
	endtask

	initial begin
		int i;
		seed   = 92690;
		errors = 0;
		cycles = 0;
		rst    = 1'b1;
		hold   = 1'b0;
		req    = '0;
		wb_in  = '0;
		wait_n = 0;
		wait_target = $unsigned($random(seed)) % 4;
		for (i = 0; i < 16; i++)
			mem[i] = 32'h8badf00d ^ (i * 32'h01010101);   // each byte tagged with the word index
		load_vectors();
		cycle_limit = vecs.size() * CYCLES_PER_ROW + CYCLE_MARGIN;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		if (res.valid !== 1'b0 || res.irq !== 1'b0 || res.y1_sel !== '0 || res.y2_sel !== '0
				|| stall !== 1'b0 || wb_out.cyc !== 1'b0 || wb_out.stb !== 1'b0)
			report_mismatch("outputs not cleared by reset");
		for (i = 0; i < vecs.size(); i++)
			run_row(i);
		$display("%0d errors in %0d rows", errors, vecs.size());
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* exec_stage.f */
+incdir+tests
hdl/exec_pkg.sv
hdl/exec_decode.sv
hdl/shift_logic_unit.sv
hdl/bitfield_compare_unit.sv
hdl/mem_access_unit.sv
hdl/result_reg.sv
hdl/exec_stage.sv
tests/exec_stage_tb.sv
